// ==== verification/adc_if_input.txt ====
// columns: lane mode (0 one lane, 1 two lanes), 18-bit sample in hex
// each sample is both the adc model output and the expected adc_data
1 3ffff
1 00000
1 20000
1 00001
1 2aaaa
1 15555
1 1c3a5
1 0f0f0
0 3ffff
0 00000
0 2aaaa
0 15555
0 24689
0 1357b
0 3c003
0 00ff0
1 12345
1 3edcb
1 2f00d
1 0b00e

// ==== verilog.f ====
hw/adc_if_pkg.sv
hw/adc_if_regs.sv
hw/adc_cnv_timer.sv
hw/adc_lane_capture.sv
hw/adc_if_top.sv
verification/adc_if_tb.sv

// ==== Makefile ====
# Verilator build and run for the adc interface testbench

VERILATOR ?= verilator
TOP       ?= adc_if_tb
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
JOBS      ?= 0
VFLAGS    ?= --binary --assert -j $(JOBS)
PASS_MSG  ?= SIMULATION PASSED

SRCS := $(shell cat $(FILELIST))
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# pass or fail comes from the log, not the exit code
run: $(BIN)
	./$(BIN) 2>&1 | tee $(LOG)
	@if grep -qF "$(PASS_MSG)" $(LOG); then \
		echo "run ok, see $(LOG)"; \
	else \
		echo "run failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== verification/adc_if_tb.sv ====
// testbench for the adc interface top level
// serial adc model fed from a sample file, timing monitor and register checks

module adc_if_tb;

  import adc_if_pkg::*;

  localparam int num_samples    = 20;
  localparam int test_period    = 40;
  localparam int rd_timeout     = 8;
  localparam int sample_timeout = 2000;

  logic                      cnv_out = 1'b0;
  logic                      rst;
  logic                      reg_wr;
  logic                      reg_rd;
  logic [reg_addr_w-1:0]     reg_addr;
  logic [31:0]               reg_wdata;
  logic [31:0]               reg_rdata;
  logic                      reg_rvalid;
  logic                      da = 1'b0;
  logic                      db = 1'b0;
  logic                      cnv;
  logic                      clk_gate;
  logic                      adc_dovf;
  logic                      adc_valid;
  logic [adc_resolution-1:0] adc_data;
  logic                      pd_cntrl;
  logic                      testpat_cntrl;
  logic                      twolanes_cntrl;

  // even entries hold the lane mode, odd entries the sample
  logic [19:0]               file_mem [0:2*num_samples-1];
  logic [adc_resolution-1:0] expect_q [$];
  logic [adc_resolution-1:0] adc_word = '0;
  logic [adc_resolution-1:0] exp_word;
  logic [adc_resolution-1:0] shifted;
  logic                      cur_mode = 1'b0;
  logic                      gate_prev = 1'b0;
  logic                      lanes_s = 1'b0;
  logic                      cnv_armed = 1'b0;
  logic                      timed_out = 1'b0;
  int cyc = 0;
  int cnv_cyc = 0;
  int rise_cyc = 0;
  int fall_cyc = 0;
  int gate_pos = 0;
  int want_len;
  int model_idx = 0;
  int valid_seen = 0;
  int ctrl_writes = 0;
  int ctrl_seen = 0;
  int main_errors = 0;
  int mon_errors = 0;
  int mon_other = 0;

  always #10 cnv_out = ~cnv_out;

  always @(posedge cnv_out) begin
    cyc <= cyc + 1;
  end

  adc_if_top adc_if_top_inst (
    .cnv_out        (cnv_out),
    .rst            (rst),
    .reg_wr         (reg_wr),
    .reg_rd         (reg_rd),
    .reg_addr       (reg_addr),
    .reg_wdata      (reg_wdata),
    .reg_rdata      (reg_rdata),
    .reg_rvalid     (reg_rvalid),
    .da             (da),
    .db             (db),
    .cnv            (cnv),
    .clk_gate       (clk_gate),
    .adc_dovf       (adc_dovf),
    .adc_valid      (adc_valid),
    .adc_data       (adc_data),
    .pd_cntrl       (pd_cntrl),
    .testpat_cntrl  (testpat_cntrl),
    .twolanes_cntrl (twolanes_cntrl)
  );

  function automatic void show_mismatch(input string what, input logic [31:0] got,
                                        input logic [31:0] want);
    $display("CHECK FAILED at %0t: %s, got %0h expected %0h", $time, what, got, want);
  endfunction

  // ----------------------------------------------------------------------
  // adc serial model sending msb first with da ahead of db
  // ----------------------------------------------------------------------

  always @(posedge cnv_out) begin
    if (gate_prev) begin
      if (lanes_s) begin
        shifted = adc_word << (2 * gate_pos);
        da <= shifted[adc_resolution-1];
        db <= shifted[adc_resolution-2];
      end else begin
        shifted = adc_word << gate_pos;
        da <= shifted[adc_resolution-1];
        db <= 1'b0;
      end
    end
  end

  // ----------------------------------------------------------------------
  // pin monitor sampled mid cycle
  // ----------------------------------------------------------------------

  always @(negedge cnv_out) begin
    if (!rst) begin
      // a ctrl write restarts the period
      if (ctrl_seen != ctrl_writes) begin
        cnv_armed = 1'b0;
      end
      ctrl_seen = ctrl_writes;
      if (cnv) begin
        if (cnv_armed) begin
          assert (cyc - cnv_cyc == test_period) else begin
            mon_errors++;
            show_mismatch("cnv spacing", cyc - cnv_cyc, test_period);
          end
        end
        cnv_armed = 1'b1;
        cnv_cyc = cyc;
        // converter picks up the next file sample
        if (model_idx < num_samples) begin
          cur_mode = file_mem[2*model_idx][0];
          adc_word = file_mem[2*model_idx+1][adc_resolution-1:0];
          expect_q.push_back(adc_word);
          model_idx++;
          assert (twolanes_cntrl == cur_mode) else begin
            mon_errors++;
            show_mismatch("twolanes pin at cnv", 32'(twolanes_cntrl), 32'(cur_mode));
          end
        end else begin
          mon_other++;
          $display("extra cnv at %0t, no sample left for the adc model", $time);
        end
      end
      if (clk_gate && !gate_prev) begin
        rise_cyc = cyc;
        gate_pos = 0;
        assert (cyc - cnv_cyc == conv_cycles) else begin
          mon_errors++;
          show_mismatch("cnv to clk_gate delay", cyc - cnv_cyc, conv_cycles);
        end
      end else if (clk_gate) begin
        gate_pos++;
      end
      if (!clk_gate && gate_prev) begin
        fall_cyc = cyc;
        want_len = cur_mode ? adc_resolution / 2 : adc_resolution;
        assert (cyc - rise_cyc == want_len) else begin
          mon_errors++;
          show_mismatch("clk_gate high time", cyc - rise_cyc, want_len);
        end
      end
      if (adc_valid) begin
        valid_seen++;
        assert (cyc - fall_cyc == 2) else begin
          mon_errors++;
          show_mismatch("clk_gate fall to adc_valid", cyc - fall_cyc, 2);
        end
        if (expect_q.size() == 0) begin
          mon_other++;
          $display("adc_valid at %0t with no conversion outstanding", $time);
        end else begin
          exp_word = expect_q.pop_front();
          assert (adc_data == exp_word) else begin
            mon_errors++;
            show_mismatch("captured sample", 32'(adc_data), 32'(exp_word));
          end
        end
      end
      gate_prev = clk_gate;
      lanes_s = twolanes_cntrl;
    end
  end

  // ----------------------------------------------------------------------
  // host register access
  // ----------------------------------------------------------------------

  task automatic write_reg(input logic [reg_addr_w-1:0] addr, input logic [31:0] data);
    @(posedge cnv_out);
    reg_wr    <= 1'b1;
    reg_addr  <= addr;
    reg_wdata <= data;
    @(posedge cnv_out);
    reg_wr <= 1'b0;
    if (addr == addr_ctrl) begin
      ctrl_writes++;
    end
  endtask

  task automatic read_reg(input logic [reg_addr_w-1:0] addr, output logic [31:0] data);
    int t;
    logic got;
    data = '0;
    if (timed_out) return;
    @(posedge cnv_out);
    reg_rd   <= 1'b1;
    reg_addr <= addr;
    @(posedge cnv_out);
    reg_rd <= 1'b0;
    got = 1'b0;
    for (t = 0; t < rd_timeout && !got; t++) begin
      @(negedge cnv_out);
      got = reg_rvalid;
    end
    if (got) begin
      data = reg_rdata;
      // rvalid belongs in the cycle right after the strobe
      assert (t == 1) else begin
        main_errors++;
        show_mismatch("read latency in cycles", t, 1);
      end
    end else begin
      timed_out = 1'b1;
      $display("timeout at %0t waiting for read data from address %0d", $time, addr);
    end
  endtask

  task automatic check_reg(input logic [reg_addr_w-1:0] addr, input logic [31:0] want,
                           input string what);
    logic [31:0] got;
    read_reg(addr, got);
    if (!timed_out) begin
      assert (got == want) else begin
        main_errors++;
        show_mismatch(what, got, want);
      end
    end
  endtask

  // wait until the adc_valid count reaches target
  task automatic wait_samples(input int target);
    int t;
    if (timed_out) return;
    t = 0;
    while (valid_seen < target && t < sample_timeout) begin
      @(posedge cnv_out);
      t++;
    end
    if (valid_seen < target) begin
      timed_out = 1'b1;
      $display("timeout at %0t, only %0d of %0d samples seen", $time, valid_seen, target);
    end
  endtask

  // one full period plus margin with no converter activity
  task automatic watch_powerdown(input int cycles);
    int t;
    if (timed_out) return;
    for (t = 0; t < cycles; t++) begin
      @(negedge cnv_out);
      assert (pd_cntrl && testpat_cntrl && !cnv && !adc_valid) else begin
        main_errors++;
        $display("CHECK FAILED at %0t: power down, pd %b testpat %b cnv %b valid %b",
                 $time, pd_cntrl, testpat_cntrl, cnv, adc_valid);
      end
    end
  endtask

  // ----------------------------------------------------------------------
  // test sequence
  // ----------------------------------------------------------------------

  initial begin
    int first;
    int last;
    logic mode;
    rst       = 1'b1;
    reg_wr    = 1'b0;
    reg_rd    = 1'b0;
    reg_addr  = '0;
    reg_wdata = '0;
    adc_dovf  = 1'b0;
    $readmemh("verification/adc_if_input.txt", file_mem);
    repeat (8) @(posedge cnv_out);
    rst <= 1'b0;
    @(negedge cnv_out);
    assert ({cnv, clk_gate, adc_valid, pd_cntrl, testpat_cntrl, twolanes_cntrl} == 6'b0)
      else begin
      main_errors++;
      $display("CHECK FAILED at %0t: control outputs not idle after reset", $time);
    end
    check_reg(addr_period, 32'd64, "period after reset");
    write_reg(addr_period, test_period);
    check_reg(addr_period, test_period, "period readback");
    // one block per run of equal lane mode in the file
    first = 0;
    while (first < num_samples && !timed_out) begin
      mode = file_mem[2*first][0];
      last = first;
      while (last + 1 < num_samples && file_mem[2*(last+1)][0] == mode) begin
        last++;
      end
      if (first != 0) begin
        // pd and testpat with enable still set and the mode switched while stopped
        write_reg(addr_ctrl, {28'd0, 1'b1, 1'b1, mode, 1'b1});
        check_reg(addr_ctrl, {28'd0, 1'b1, 1'b1, mode, 1'b1}, "ctrl readback in power down");
        watch_powerdown(test_period + 10);
      end
      write_reg(addr_ctrl, {28'd0, 1'b0, 1'b0, mode, 1'b1});
      check_reg(addr_ctrl, {28'd0, 1'b0, 1'b0, mode, 1'b1}, "ctrl readback");
      wait_samples(last + 1);
      first = last + 1;
    end
    write_reg(addr_ctrl, 32'd0);
    // sticky overflow flag
    check_reg(addr_status, 32'd0, "status before overflow");
    @(posedge cnv_out);
    adc_dovf <= 1'b1;
    @(posedge cnv_out);
    adc_dovf <= 1'b0;
    check_reg(addr_status, 32'd1, "status after dovf pulse");
    check_reg(addr_status, 32'd1, "status still set");
    // set and clear in the same cycle
    @(posedge cnv_out);
    adc_dovf  <= 1'b1;
    reg_wr    <= 1'b1;
    reg_addr  <= addr_status;
    reg_wdata <= 32'd1;
    @(posedge cnv_out);
    adc_dovf <= 1'b0;
    reg_wr   <= 1'b0;
    check_reg(addr_status, 32'd1, "status with set against clear");
    write_reg(addr_status, 32'd1);
    check_reg(addr_status, 32'd0, "status after clear");
    // sample counter
    check_reg(addr_count, valid_seen, "sample count");
    write_reg(addr_count, 32'd0);
    check_reg(addr_count, 32'd0, "sample count after clear");
    assert (expect_q.size() == 0) else begin
      main_errors++;
      $display("CHECK FAILED at %0t: %0d conversions never captured", $time, expect_q.size());
    end
    $display("error count: %0d failed checks, %0d other errors",
             main_errors + mon_errors, mon_other + (timed_out ? 1 : 0));
    if (main_errors == 0 && mon_errors == 0 && mon_other == 0 && !timed_out) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

// ==== hw/adc_if_top.sv ====
// adc interface top level
// joins register block, conversion timer and lane capture

module adc_if_top (
  input  logic                                  cnv_out,
  input  logic                                  rst,
  // host register strobes
  input  logic                                  reg_wr,
  input  logic                                  reg_rd,
  input  logic [adc_if_pkg::reg_addr_w-1:0]     reg_addr,
  input  logic [31:0]                           reg_wdata,
  output logic [31:0]                           reg_rdata,
  output logic                                  reg_rvalid,
  // adc serial side
  input  logic                                  da,
  input  logic                                  db,
  output logic                                  cnv,
  output logic                                  clk_gate,
  // dma side
  input  logic                                  adc_dovf,
  output logic                                  adc_valid,
  output logic [adc_if_pkg::adc_resolution-1:0] adc_data,
  // adc mode pins
  output logic                                  pd_cntrl,
  output logic                                  testpat_cntrl,
  output logic                                  twolanes_cntrl
);

  import adc_if_pkg::*;

  adc_cfg_t    cfg;
  adc_sample_t sample;
  logic        sample_strobe;

  // ----------------------------------------------------------------------
  // blocks
  // ----------------------------------------------------------------------

  adc_if_regs adc_if_regs_inst (
    .cnv_out       (cnv_out),
    .rst           (rst),
    .reg_wr        (reg_wr),
    .reg_rd        (reg_rd),
    .reg_addr      (reg_addr),
    .reg_wdata     (reg_wdata),
    .adc_dovf      (adc_dovf),
    .sample_strobe (sample_strobe),
    .reg_rdata     (reg_rdata),
    .reg_rvalid    (reg_rvalid),
    .cfg           (cfg)
  );

  adc_cnv_timer adc_cnv_timer_inst (
    .cnv_out  (cnv_out),
    .rst      (rst),
    .cfg      (cfg),
    .cnv      (cnv),
    .clk_gate (clk_gate)
  );

  adc_lane_capture adc_lane_capture_inst (
    .cnv_out       (cnv_out),
    .rst           (rst),
    .cfg           (cfg),
    .clk_gate      (clk_gate),
    .da            (da),
    .db            (db),
    .sample        (sample),
    .sample_strobe (sample_strobe)
  );

  // sample word out to dma
  assign adc_valid      = sample.valid;
  assign adc_data       = sample.data;
  // mode pins straight from config
  assign pd_cntrl       = cfg.pd;
  assign testpat_cntrl  = cfg.testpat;
  assign twolanes_cntrl = cfg.twolanes;

endmodule

// ==== hw/adc_lane_capture.sv ====
// lane capture
// deserializes da, or da and db, into an 18-bit sample with a valid strobe

module adc_lane_capture (
  input  logic                    cnv_out,
  input  logic                    rst,
  input  adc_if_pkg::adc_cfg_t    cfg,
  input  logic                    clk_gate,
  input  logic                    da,
  input  logic                    db,
  output adc_if_pkg::adc_sample_t sample,
  output logic                    sample_strobe
);

  import adc_if_pkg::*;

  logic                      gate_d;
  logic                      gate_dd;
  logic [adc_resolution-1:0] shift_q;
  logic                      valid_q;
  logic [adc_resolution-1:0] data_q;
  logic                      gate_fall;

  // bits launched at gated edges land one cycle later
  always_ff @(posedge cnv_out) begin
    if (rst) begin
      gate_d  <= 1'b0;
      gate_dd <= 1'b0;
    end else begin
      gate_d  <= clk_gate;
      gate_dd <= gate_d;
    end
  end

  // delayed gate just dropped, word complete
  assign gate_fall = gate_dd && !gate_d;

  // ----------------------------------------------------------------------
  // deserializer, msb first
  // ----------------------------------------------------------------------

  always_ff @(posedge cnv_out) begin
    if (gate_d) begin
      if (cfg.twolanes) begin
        // da carries the higher bit of each pair
        shift_q <= {shift_q[adc_resolution-3:0], da, db};
      end else begin
        shift_q <= {shift_q[adc_resolution-2:0], da};
      end
    end
  end

  // ----------------------------------------------------------------------
  // output word
  // ----------------------------------------------------------------------

  always_ff @(posedge cnv_out) begin
    if (rst) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= gate_fall;
    end
  end

  always_ff @(posedge cnv_out) begin
    if (gate_fall) begin
      data_q <= shift_q;
    end
  end

  assign sample        = '{valid: valid_q, data: data_q};
  // same pulse feeds the sample counter
  assign sample_strobe = valid_q;

endmodule

// ==== hw/adc_cnv_timer.sv ====
// conversion timer
// periodic cnv pulse, conversion wait, then the gated bit clock window

module adc_cnv_timer (
  input  logic                 cnv_out,
  input  logic                 rst,
  input  adc_if_pkg::adc_cfg_t cfg,
  output logic                 cnv,
  output logic                 clk_gate
);

  import adc_if_pkg::*;

  logic        run;
  logic [15:0] period_cnt;
  logic        waiting;
  logic [2:0]  wait_cnt;
  logic [4:0]  bit_cnt;

  // new pulses only while enabled and powered up
  assign run = cfg.enable && !cfg.pd;

  // ----------------------------------------------------------------------
  // period counter
  // ----------------------------------------------------------------------

  always_ff @(posedge cnv_out) begin
    if (rst) begin
      period_cnt <= '0;
      cnv        <= 1'b0;
    end else if (!run) begin
      // hold off, restart period on next enable
      period_cnt <= '0;
      cnv        <= 1'b0;
    end else if (period_cnt >= cfg.cnv_period - 16'd1) begin
      // >= so a shortened period does not run to wrap
      period_cnt <= '0;
      cnv        <= 1'b1;
    end else begin
      period_cnt <= period_cnt + 16'd1;
      cnv        <= 1'b0;
    end
  end

  // ----------------------------------------------------------------------
  // conversion wait and gate window
  // ----------------------------------------------------------------------

  // cnv high in cycle t -> gate high from t + conv_cycles
  always_ff @(posedge cnv_out) begin
    if (rst) begin
      waiting  <= 1'b0;
      wait_cnt <= '0;
      clk_gate <= 1'b0;
      bit_cnt  <= '0;
    end else if (cnv) begin
      // arm the wait, counts down to zero
      waiting  <= 1'b1;
      wait_cnt <= 3'(conv_cycles - 2);
    end else if (waiting) begin
      if (wait_cnt == 3'd0) begin
        waiting  <= 1'b0;
        clk_gate <= 1'b1;
        // window length depends on lane count
        bit_cnt  <= cfg.twolanes ? 5'(lane_bits_two - 1) : 5'(lane_bits_one - 1);
      end else begin
        wait_cnt <= wait_cnt - 3'd1;
      end
    end else if (clk_gate) begin
      // open window always runs to the end
      if (bit_cnt == 5'd0) begin
        clk_gate <= 1'b0;
      end else begin
        bit_cnt <= bit_cnt - 5'd1;
      end
    end
  end

endmodule

// ==== hw/adc_if_regs.sv ====
// adc interface register block
// control, conversion period, sticky overflow and sample count, with readback

module adc_if_regs (
  input  logic                              cnv_out,
  input  logic                              rst,
  input  logic                              reg_wr,
  input  logic                              reg_rd,
  input  logic [adc_if_pkg::reg_addr_w-1:0] reg_addr,
  input  logic [31:0]                       reg_wdata,
  input  logic                              adc_dovf,
  input  logic                              sample_strobe,
  output logic [31:0]                       reg_rdata,
  output logic                              reg_rvalid,
  output adc_if_pkg::adc_cfg_t              cfg
);

  import adc_if_pkg::*;

  logic        dovf_sticky;
  logic [31:0] sample_cnt;
  logic [31:0] rd_word;
  logic        wr_ctrl;
  logic        wr_period;
  logic        wr_status;
  logic        wr_count;

  // write decode
  assign wr_ctrl   = reg_wr && (reg_addr == addr_ctrl);
  assign wr_period = reg_wr && (reg_addr == addr_period);
  assign wr_status = reg_wr && (reg_addr == addr_status);
  assign wr_count  = reg_wr && (reg_addr == addr_count);

  // ----------------------------------------------------------------------
  // configuration registers
  // ----------------------------------------------------------------------

  // ctrl holds enable in bit 0, then twolanes, testpat and pd
  always_ff @(posedge cnv_out) begin
    if (rst) begin
      cfg <= '{enable: 1'b0, twolanes: 1'b0, testpat: 1'b0, pd: 1'b0,
               cnv_period: cnv_period_rst};
    end else begin
      if (wr_ctrl) begin
        cfg.enable   <= reg_wdata[0];
        cfg.twolanes <= reg_wdata[1];
        cfg.testpat  <= reg_wdata[2];
        cfg.pd       <= reg_wdata[3];
      end
      if (wr_period) begin
        cfg.cnv_period <= reg_wdata[15:0];
      end
    end
  end

  // ----------------------------------------------------------------------
  // status and sample counter
  // ----------------------------------------------------------------------

  always_ff @(posedge cnv_out) begin
    if (rst) begin
      dovf_sticky <= 1'b0;
      sample_cnt  <= '0;
    end else begin
      // set beats a clear in the same cycle
      if (adc_dovf) begin
        dovf_sticky <= 1'b1;
      end else if (wr_status && reg_wdata[0]) begin
        dovf_sticky <= 1'b0;
      end
      // any write to count address zeroes it
      if (wr_count) begin
        sample_cnt <= '0;
      end else if (sample_strobe) begin
        sample_cnt <= sample_cnt + 32'd1;
      end
    end
  end

  // ----------------------------------------------------------------------
  // readback with one cycle latency
  // ----------------------------------------------------------------------

  always_comb begin
    case (reg_addr)
      addr_ctrl:   rd_word = {28'd0, cfg.pd, cfg.testpat, cfg.twolanes, cfg.enable};
      addr_period: rd_word = {16'd0, cfg.cnv_period};
      addr_status: rd_word = {31'd0, dovf_sticky};
      default:     rd_word = sample_cnt;
    endcase
  end

  always_ff @(posedge cnv_out) begin
    if (rst) begin
      reg_rvalid <= 1'b0;
    end else begin
      reg_rvalid <= reg_rd;
    end
  end

  // word of the strobed address
  always_ff @(posedge cnv_out) begin
    if (reg_rd) begin
      reg_rdata <= rd_word;
    end
  end

endmodule

// ==== hw/adc_if_pkg.sv ====
// adc interface package
// shared constants, register map and the config / sample word layouts

package adc_if_pkg;

  // ----------------------------------------------------------------------
  // converter geometry
  // ----------------------------------------------------------------------

  // sample width of the sar core
  localparam int adc_resolution = 18;
  // cycles from cnv pulse to first gated bit clock
  localparam int conv_cycles = 4;
  // gated clock cycles per sample, per lane mode
  localparam int lane_bits_one = adc_resolution;
  localparam int lane_bits_two = adc_resolution / 2;

  // ----------------------------------------------------------------------
  // host register map
  // ----------------------------------------------------------------------

  localparam int reg_addr_w = 2;
  localparam logic [reg_addr_w-1:0] addr_ctrl = 2'd0;
  localparam logic [reg_addr_w-1:0] addr_period = 2'd1;
  localparam logic [reg_addr_w-1:0] addr_status = 2'd2;
  localparam logic [reg_addr_w-1:0] addr_count = 2'd3;
  // default conversion period after reset
  localparam logic [15:0] cnv_period_rst = 16'd64;

  // live configuration, enable sits in the msb
  typedef struct packed {
    logic        enable;
    logic        twolanes;
    logic        testpat;
    logic        pd;
    logic [15:0] cnv_period;
  } adc_cfg_t;

  // one captured result
  typedef struct packed {
    logic                      valid;
    logic [adc_resolution-1:0] data;
  } adc_sample_t;

endpackage
